// ==== include/dcache_params.svh ====
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Byte address and data word widths
`define DC_ADDR_W  32
`define DC_DATA_W  32

// 16-byte lines
`define DC_BLOCK_W 4

// 16 sets
`define DC_SET_W   4

// Two ways, one LRU bit per set
`define DC_WAYS    2

// Tag is what is left above index and offset
`define DC_TAG_W   (`DC_ADDR_W - `DC_BLOCK_W - `DC_SET_W)

// Words per line
`define DC_WORDS   (1 << (`DC_BLOCK_W - 2))

`endif

// ==== rtl/dcache_pkg.sv ====
`include "dcache_params.svh"

package dcache_pkg;

   // Access FSM states
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      REFILL_REQ,
      REFILL_WAIT,
      WRITE_MEM,
      DONE
   } dc_state_t;

   // CPU opcodes
   typedef enum logic [1:0] {
      OP_READ  = 2'b00,
      OP_WRITE = 2'b01,
      OP_INVAL = 2'b10
   } dc_op_t;

   // Data word and byte address
   typedef logic [`DC_DATA_W-1:0] dc_word_t;
   typedef logic [`DC_ADDR_W-1:0] dc_addr_t;

   // Tag and set index fields
   typedef logic [`DC_TAG_W-1:0] dc_tag_t;
   typedef logic [`DC_SET_W-1:0] dc_index_t;

   // One bit per way, one-hot
   typedef logic [`DC_WAYS-1:0] dc_way_vec_t;

   // One select per byte lane
   typedef logic [`DC_DATA_W/8-1:0] dc_bsel_t;

endpackage

// ==== rtl/dcache_tag_store.sv ====
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_tag_store
   import dcache_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        lookup_i,
   input  dc_addr_t    adr_i,
   input  logic        touch_i,
   input  logic        fill_i,
   input  logic        inval_i,
   output dc_way_vec_t way_hit_o,
   output dc_way_vec_t victim_o
);

   // Tag array per way, indexed by set
   dc_tag_t tag_mem [`DC_WAYS][1 << `DC_SET_W];

   // Valid bits per way, one per set
   logic [(1 << `DC_SET_W)-1:0] valid_q [`DC_WAYS];

   // LRU bit per set gives the way to replace next
   logic [(1 << `DC_SET_W)-1:0] lru_q;

   // Lookup address held for compare, fill and invalidate
   dc_tag_t   tag_q;
   dc_index_t index_q;

   dc_way_vec_t way_hit;
   dc_way_vec_t victim;
   logic        lru_bit;

   // Latch tag and set when the control unit starts a lookup
   always_ff @(posedge clk) begin
      if (lookup_i) begin
         tag_q   <= adr_i[`DC_ADDR_W-1 -: `DC_TAG_W];
         index_q <= adr_i[`DC_BLOCK_W +: `DC_SET_W];
      end
   end

   // Compare against the latched set one cycle after lookup
   // Also sees a fill from the previous edge
   always_comb begin
      for (int w = 0; w < `DC_WAYS; w++) begin
         way_hit[w] = valid_q[w][index_q] && (tag_mem[w][index_q] == tag_q);
      end
   end

   assign lru_bit = lru_q[index_q];

   // Victim is the way the LRU bit points at
   assign victim = {lru_bit, ~lru_bit};

   assign way_hit_o = way_hit;
   assign victim_o  = victim;

   // Tag write into the victim way on refill completion
   always_ff @(posedge clk) begin
      if (fill_i) begin
         for (int w = 0; w < `DC_WAYS; w++) begin
            if (victim[w]) begin
               tag_mem[w][index_q] <= tag_q;
            end
         end
      end
   end

   // Valid and LRU update
   always_ff @(posedge clk) begin
      if (rst) begin
         lru_q <= '0;
         for (int w = 0; w < `DC_WAYS; w++) begin
            valid_q[w] <= '0;
         end
      end else if (inval_i) begin
         // Block invalidate clears both ways of the set
         for (int w = 0; w < `DC_WAYS; w++) begin
            valid_q[w][index_q] <= 1'b0;
         end
         lru_q[index_q] <= 1'b0;
      end else if (fill_i) begin
         for (int w = 0; w < `DC_WAYS; w++) begin
            if (victim[w]) begin
               valid_q[w][index_q] <= 1'b1;
            end
         end
         // Point away from the way just filled
         lru_q[index_q] <= victim[0];
      end else if (touch_i) begin
         // Point away from the way that hit
         lru_q[index_q] <= way_hit[0];
      end
   end

endmodule

// ==== rtl/dcache_data_store.sv ====
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_data_store
   import dcache_pkg::*;
(
   input  logic                             clk,
   input  logic [`DC_SET_W+`DC_BLOCK_W-3:0] rd_adr_i,
   input  logic                             wr_en_i,
   input  dc_way_vec_t                      wr_way_i,
   input  logic [`DC_SET_W+`DC_BLOCK_W-3:0] wr_adr_i,
   input  dc_word_t                         wr_dat_i,
   input  dc_bsel_t                         wr_bsel_i,
   output dc_word_t                         way_dat_o [`DC_WAYS]
);

   // Words per way memory
   localparam int DEPTH = (1 << `DC_SET_W) * `DC_WORDS;

   // One word memory per way
   for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way

      dc_word_t mem [DEPTH];

      // Byte lanes written only where selected
      always_ff @(posedge clk) begin
         if (wr_en_i && wr_way_i[w]) begin
            for (int b = 0; b < `DC_DATA_W/8; b++) begin
               if (wr_bsel_i[b]) begin
                  mem[wr_adr_i][8*b +: 8] <= wr_dat_i[8*b +: 8];
               end
            end
         end
      end

      // Registered read every cycle
      // A write on the same edge is not seen until the next read
      always_ff @(posedge clk) begin
         way_dat_o[w] <= mem[rd_adr_i];
      end

   end

endmodule

// ==== rtl/dcache_ctrl.sv ====
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_ctrl
   import dcache_pkg::*;
(
   input  logic                             clk,
   input  logic                             rst,
   // CPU port
   input  logic                             cpu_req_i,
   input  dc_op_t                           cpu_op_i,
   input  dc_addr_t                         cpu_adr_i,
   input  dc_word_t                         cpu_dat_i,
   input  dc_bsel_t                         cpu_bsel_i,
   output logic                             cpu_ack_o,
   output dc_word_t                         cpu_dat_o,
   // Memory port
   output logic                             mem_req_o,
   output logic                             mem_we_o,
   output dc_addr_t                         mem_adr_o,
   output dc_word_t                         mem_dat_o,
   output dc_bsel_t                         mem_bsel_o,
   input  logic                             mem_ack_i,
   input  dc_word_t                         mem_dat_i,
   // Tag store
   input  dc_way_vec_t                      way_hit_i,
   input  dc_way_vec_t                      victim_i,
   output logic                             lookup_o,
   output logic                             touch_o,
   output logic                             fill_o,
   output logic                             inval_o,
   // Data store
   input  dc_word_t                         way_dat_i [`DC_WAYS],
   output logic [`DC_SET_W+`DC_BLOCK_W-3:0] rd_adr_o,
   output logic                             wr_en_o,
   output dc_way_vec_t                      wr_way_o,
   output logic [`DC_SET_W+`DC_BLOCK_W-3:0] wr_adr_o,
   output dc_word_t                         wr_dat_o,
   output dc_bsel_t                         wr_bsel_o
);

   // Word offset bits inside a line
   localparam int WORD_W = `DC_BLOCK_W - 2;

   dc_state_t         state_q;
   dc_state_t         state_d;
   logic [WORD_W-1:0] cnt_q;
   dc_way_vec_t       victim_q;
   dc_word_t          rdata_q;
   logic              hit;
   logic              last_word;
   dc_way_vec_t       sel_way;
   dc_word_t          sel_word;

   assign hit       = |way_hit_i;
   assign last_word = (cnt_q == WORD_W'(`DC_WORDS - 1));

   // Hit way on a hit and the refill way otherwise
   assign sel_way = hit ? way_hit_i : victim_q;

   always_comb begin
      sel_word = way_dat_i[0];
      for (int w = 0; w < `DC_WAYS; w++) begin
         if (sel_way[w]) begin
            sel_word = way_dat_i[w];
         end
      end
   end

   // Data store always reads the requested word
   assign rd_adr_o = cpu_adr_i[`DC_BLOCK_W+`DC_SET_W-1:2];

   // CPU side
   assign cpu_ack_o = (state_q == DONE);
   assign cpu_dat_o = rdata_q;

   // Refill walks the line word by word on the memory side
   assign mem_req_o  = (state_q == REFILL_REQ) || (state_q == WRITE_MEM);
   assign mem_we_o   = (state_q == WRITE_MEM);
   assign mem_dat_o  = cpu_dat_i;
   assign mem_bsel_o = mem_we_o ? cpu_bsel_i : '1;
   assign mem_adr_o  = mem_we_o ? {cpu_adr_i[`DC_ADDR_W-1:2], 2'b00}
                                : {cpu_adr_i[`DC_ADDR_W-1:`DC_BLOCK_W], cnt_q, 2'b00};

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q  <= IDLE;
         cnt_q    <= '0;
         victim_q <= '0;
      end else begin
         state_q <= state_d;
         // Read miss starts a refill at word 0 and keeps the victim
         if (state_q == LOOKUP && cpu_op_i == OP_READ && !hit) begin
            cnt_q    <= '0;
            victim_q <= victim_i;
         end else if (state_q == REFILL_WAIT && !mem_ack_i) begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   // Read data captured while the lookup result is valid
   always_ff @(posedge clk) begin
      if (state_q == LOOKUP) begin
         rdata_q <= sel_word;
      end
   end

   always_comb begin
      state_d   = state_q;
      lookup_o  = 1'b0;
      touch_o   = 1'b0;
      fill_o    = 1'b0;
      inval_o   = 1'b0;
      wr_en_o   = 1'b0;
      wr_way_o  = way_hit_i;
      wr_adr_o  = cpu_adr_i[`DC_BLOCK_W+`DC_SET_W-1:2];
      wr_dat_o  = cpu_dat_i;
      wr_bsel_o = cpu_bsel_i;
      case (state_q)
         IDLE: begin
            // Both stores read in this cycle
            if (cpu_req_i) begin
               lookup_o = 1'b1;
               state_d  = LOOKUP;
            end
         end
         LOOKUP: begin
            case (cpu_op_i)
               OP_INVAL: begin
                  inval_o = 1'b1;
                  state_d = DONE;
               end
               OP_WRITE: begin
                  // Update the cached copy only on a hit
                  if (hit) begin
                     wr_en_o = 1'b1;
                     touch_o = 1'b1;
                  end
                  state_d = WRITE_MEM;
               end
               default: begin
                  if (hit) begin
                     touch_o = 1'b1;
                     state_d = DONE;
                  end else begin
                     state_d = REFILL_REQ;
                  end
               end
            endcase
         end
         REFILL_REQ: begin
            // Memory word goes into the victim way on first ack
            if (mem_ack_i) begin
               wr_en_o   = 1'b1;
               wr_way_o  = victim_q;
               wr_adr_o  = {cpu_adr_i[`DC_BLOCK_W +: `DC_SET_W], cnt_q};
               wr_dat_o  = mem_dat_i;
               wr_bsel_o = '1;
               state_d   = REFILL_WAIT;
            end
         end
         REFILL_WAIT: begin
            // Wait for ack low before the next word
            if (!mem_ack_i) begin
               if (last_word) begin
                  fill_o  = 1'b1;
                  state_d = LOOKUP;
               end else begin
                  state_d = REFILL_REQ;
               end
            end
         end
         WRITE_MEM: begin
            if (mem_ack_i) begin
               state_d = DONE;
            end
         end
         DONE: begin
            // Hold ack until the CPU and memory have both let go
            if (!cpu_req_i && !mem_ack_i) begin
               state_d = IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

endmodule

// ==== rtl/dcache_top.sv ====
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_top
   import dcache_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   // CPU port
   input  logic     cpu_req_i,
   input  dc_op_t   cpu_op_i,
   input  dc_addr_t cpu_adr_i,
   input  dc_word_t cpu_dat_i,
   input  dc_bsel_t cpu_bsel_i,
   output logic     cpu_ack_o,
   output dc_word_t cpu_dat_o,
   // Memory port
   output logic     mem_req_o,
   output logic     mem_we_o,
   output dc_addr_t mem_adr_o,
   output dc_word_t mem_dat_o,
   output dc_bsel_t mem_bsel_o,
   input  logic     mem_ack_i,
   input  dc_word_t mem_dat_i
);

   // Tag store controls and results
   logic        lookup;
   logic        touch;
   logic        fill;
   logic        inval;
   dc_way_vec_t way_hit;
   dc_way_vec_t victim;

   // Data store access
   logic [`DC_SET_W+`DC_BLOCK_W-3:0] rd_adr;
   logic [`DC_SET_W+`DC_BLOCK_W-3:0] wr_adr;
   logic                             wr_en;
   dc_way_vec_t                      wr_way;
   dc_word_t                         wr_dat;
   dc_bsel_t                         wr_bsel;
   dc_word_t                         way_dat [`DC_WAYS];

   dcache_tag_store u_tag_store (
      .clk       (clk),
      .rst       (rst),
      .lookup_i  (lookup),
      .adr_i     (cpu_adr_i),
      .touch_i   (touch),
      .fill_i    (fill),
      .inval_i   (inval),
      .way_hit_o (way_hit),
      .victim_o  (victim)
   );

   dcache_data_store u_data_store (
      .clk       (clk),
      .rd_adr_i  (rd_adr),
      .wr_en_i   (wr_en),
      .wr_way_i  (wr_way),
      .wr_adr_i  (wr_adr),
      .wr_dat_i  (wr_dat),
      .wr_bsel_i (wr_bsel),
      .way_dat_o (way_dat)
   );

   dcache_ctrl u_ctrl (
      .clk        (clk),
      .rst        (rst),
      .cpu_req_i  (cpu_req_i),
      .cpu_op_i   (cpu_op_i),
      .cpu_adr_i  (cpu_adr_i),
      .cpu_dat_i  (cpu_dat_i),
      .cpu_bsel_i (cpu_bsel_i),
      .cpu_ack_o  (cpu_ack_o),
      .cpu_dat_o  (cpu_dat_o),
      .mem_req_o  (mem_req_o),
      .mem_we_o   (mem_we_o),
      .mem_adr_o  (mem_adr_o),
      .mem_dat_o  (mem_dat_o),
      .mem_bsel_o (mem_bsel_o),
      .mem_ack_i  (mem_ack_i),
      .mem_dat_i  (mem_dat_i),
      .way_hit_i  (way_hit),
      .victim_i   (victim),
      .lookup_o   (lookup),
      .touch_o    (touch),
      .fill_o     (fill),
      .inval_o    (inval),
      .way_dat_i  (way_dat),
      .rd_adr_o   (rd_adr),
      .wr_en_o    (wr_en),
      .wr_way_o   (wr_way),
      .wr_adr_o   (wr_adr),
      .wr_dat_o   (wr_dat),
      .wr_bsel_o  (wr_bsel)
   );

endmodule

// ==== verif/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb
   import dcache_pkg::*;
();

   localparam int ACK_TIMEOUT = 200;
   localparam int RANDOM_OPS  = 200;

   logic        clk = 1'b0;
   logic        rst;
   logic        cpu_req_i;
   dc_op_t      cpu_op_i;
   logic [31:0] cpu_adr_i;
   logic [31:0] cpu_dat_i;
   logic [3:0]  cpu_bsel_i;
   logic        cpu_ack_o;
   logic [31:0] cpu_dat_o;
   logic        mem_req_o;
   logic        mem_we_o;
   logic [31:0] mem_adr_o;
   logic [31:0] mem_dat_o;
   logic [3:0]  mem_bsel_o;
   logic        mem_ack_i;
   logic [31:0] mem_dat_i;

   int stim_seed = 32'h4194_f6d5;
   int mem_seed  = 32'h4194_f6d5;

   // Memory model image and its reference copy
   // Words never written come from a hash
   logic [31:0] mem_img [logic [31:0]];
   logic [31:0] ref_img [logic [31:0]];
   // Reference cache state of 2 ways by 16 sets
   logic [23:0] ref_tag [2][16];
   logic        ref_valid [2][16];
   logic        ref_lru [16];

   // Expected results of the access in flight
   dc_op_t      exp_op;
   logic [31:0] exp_word;
   logic [31:0] exp_adr;
   logic [31:0] exp_dat;
   logic [3:0]  exp_bsel;
   int          exp_reads;
   int          exp_writes;
   // Observed memory traffic
   int          rd_cnt;
   int          wr_cnt;
   logic [31:0] rd_adrs [$];
   logic [31:0] wr_adr_q;
   logic [31:0] wr_dat_q;
   logic [3:0]  wr_bsel_q;

   int err_cnt = 0;
   int test_cnt = 0;
   int test_fail = 0;
   int test_err_start;
   logic ack_seen = 1'b0;
   logic timed_out = 1'b0;

   dcache_top DUT (
      .clk        (clk),
      .rst        (rst),
      .cpu_req_i  (cpu_req_i),
      .cpu_op_i   (cpu_op_i),
      .cpu_adr_i  (cpu_adr_i),
      .cpu_dat_i  (cpu_dat_i),
      .cpu_bsel_i (cpu_bsel_i),
      .cpu_ack_o  (cpu_ack_o),
      .cpu_dat_o  (cpu_dat_o),
      .mem_req_o  (mem_req_o),
      .mem_we_o   (mem_we_o),
      .mem_adr_o  (mem_adr_o),
      .mem_dat_o  (mem_dat_o),
      .mem_bsel_o (mem_bsel_o),
      .mem_ack_i  (mem_ack_i),
      .mem_dat_i  (mem_dat_i)
   );

   always #50 clk = ~clk;

   // Fill pattern mixes every address bit
   function automatic logic [31:0] hash_word(input logic [31:0] a);
      return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a3c_0f96;
   endfunction

   function automatic logic [31:0] mem_word(input logic [31:0] a);
      return mem_img.exists(a) ? mem_img[a] : hash_word(a);
   endfunction

   function automatic logic [31:0] ref_word(input logic [31:0] a);
      return ref_img.exists(a) ? ref_img[a] : hash_word(a);
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] dat,
                                               input logic [3:0] bsel);
      logic [31:0] w;
      w = old;
      for (int b = 0; b < 4; b++) begin
         if (bsel[b]) w[8*b +: 8] = dat[8*b +: 8];
      end
      return w;
   endfunction

   // Reference cache where the LRU bit names the next victim way
   function automatic void ref_access(input dc_op_t op, input logic [31:0] adr,
                                      input logic [31:0] dat, input logic [3:0] bsel,
                                      output logic [31:0] word, output logic refill);
      logic [3:0]  idx;
      logic [31:0] wa;
      int          hw;
      int          v;
      idx = adr[7:4];
      wa = {adr[31:2], 2'b00};
      hw = -1;
      refill = 1'b0;
      for (int w = 0; w < 2; w++) begin
         if (ref_valid[w][idx] && ref_tag[w][idx] == adr[31:8]) hw = w;
      end
      if (op == OP_INVAL) begin
         ref_valid[0][idx] = 1'b0;
         ref_valid[1][idx] = 1'b0;
         ref_lru[idx] = 1'b0;
      end else if (op == OP_WRITE) begin
         // Write through without allocation
         ref_img[wa] = merge_bytes(ref_word(wa), dat, bsel);
         if (hw >= 0) ref_lru[idx] = (hw == 0);
      end else begin
         if (hw < 0) begin
            refill = 1'b1;
            v = ref_lru[idx];
            ref_tag[v][idx] = adr[31:8];
            ref_valid[v][idx] = 1'b1;
            hw = v;
         end
         ref_lru[idx] = (hw == 0);
      end
      word = ref_word(wa);
   endfunction

   task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                  input logic [31:0] got);
      $display("[FAIL] %0t %s expected %h got %h", $time, sig, exp, got);
      err_cnt++;
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout while waiting for %s at %0t", what, $time);
      timed_out = 1'b1;
      err_cnt++;
   endtask

   // Memory model answers after 0 to 3 cycles
   always @(posedge clk) begin : mem_model
      int dly;
      logic busy;
      if (rst) begin
         mem_ack_i <= 1'b0;
         busy = 1'b0;
      end else if (mem_ack_i) begin
         if (!mem_req_o) mem_ack_i <= 1'b0;
      end else if (mem_req_o) begin
         if (!busy) begin
            dly = $random(mem_seed) & 3;
            busy = 1'b1;
         end
         if (dly == 0) begin
            busy = 1'b0;
            mem_ack_i <= 1'b1;
            if (mem_we_o) begin
               mem_img[mem_adr_o] = merge_bytes(mem_word(mem_adr_o), mem_dat_o, mem_bsel_o);
               wr_adr_q = mem_adr_o;
               wr_dat_q = mem_dat_o;
               wr_bsel_q = mem_bsel_o;
               wr_cnt++;
            end else begin
               mem_dat_i <= mem_word(mem_adr_o);
               rd_adrs.push_back(mem_adr_o);
               rd_cnt++;
            end
         end else begin
            dly--;
         end
      end
   end

   // Checks each access when its ack first shows
   always @(negedge clk) begin
      if (cpu_ack_o && !ack_seen) begin
         ack_seen = 1'b1;
         if (exp_op == OP_READ && cpu_dat_o !== exp_word)
            report_mismatch("cpu_dat_o", exp_word, cpu_dat_o);
         if (rd_cnt != exp_reads) report_mismatch("mem read count", exp_reads, rd_cnt);
         if (wr_cnt != exp_writes) report_mismatch("mem write count", exp_writes, wr_cnt);
         // Refill walks words 0 to 3 of the line
         for (int i = 0; i < rd_adrs.size() && i < 4; i++) begin
            if (rd_adrs[i] !== {exp_adr[31:4], i[1:0], 2'b00})
               report_mismatch("mem_adr_o", {exp_adr[31:4], i[1:0], 2'b00}, rd_adrs[i]);
         end
         if (exp_writes == 1 && wr_cnt == 1) begin
            if (wr_adr_q !== {exp_adr[31:2], 2'b00})
               report_mismatch("mem_adr_o", {exp_adr[31:2], 2'b00}, wr_adr_q);
            if (wr_bsel_q !== exp_bsel) report_mismatch("mem_bsel_o", exp_bsel, wr_bsel_q);
            if (merge_bytes(0, wr_dat_q, exp_bsel) !== merge_bytes(0, exp_dat, exp_bsel))
               report_mismatch("mem_dat_o", exp_dat, wr_dat_q);
         end
      end else if (!cpu_ack_o) begin
         ack_seen = 1'b0;
      end
   end

   // One four-phase CPU access starting from a falling edge
   task automatic run_access(input dc_op_t op, input logic [31:0] adr,
                             input logic [31:0] dat, input logic [3:0] bsel);
      logic [31:0] word;
      logic        refill;
      int          n;
      if (timed_out) return;
      ref_access(op, adr, dat, bsel, word, refill);
      exp_op = op;
      exp_word = word;
      exp_reads = refill ? 4 : 0;
      exp_writes = (op == OP_WRITE) ? 1 : 0;
      exp_adr = adr;
      exp_dat = dat;
      exp_bsel = bsel;
      rd_cnt = 0;
      wr_cnt = 0;
      rd_adrs.delete();
      @(posedge clk);
      cpu_req_i <= 1'b1;
      cpu_op_i <= op;
      cpu_adr_i <= adr;
      cpu_dat_i <= dat;
      cpu_bsel_i <= bsel;
      n = 0;
      @(negedge clk);
      while (!cpu_ack_o && !timed_out) begin
         n++;
         if (n > ACK_TIMEOUT) begin
            report_timeout("cpu_ack_o high");
         end else begin
            @(negedge clk);
         end
      end
      if (timed_out) return;
      // Hits and invalidates take a fixed 2 cycles
      if (op != OP_WRITE && !refill && n != 2) report_mismatch("ack latency", 2, n);
      @(posedge clk);
      cpu_req_i <= 1'b0;
      n = 0;
      @(negedge clk);
      while (cpu_ack_o && !timed_out) begin
         n++;
         if (n > ACK_TIMEOUT) begin
            report_timeout("cpu_ack_o low");
         end else begin
            @(negedge clk);
         end
      end
   endtask

   task automatic start_test();
      test_err_start = err_cnt;
   endtask

   task automatic finish_test(input string name);
      test_cnt++;
      if (err_cnt != test_err_start) begin
         test_fail++;
         $display("Test %s: FAIL with %0d errors", name, err_cnt - test_err_start);
      end else begin
         $display("Test %s: ok", name);
      end
   endtask

   initial begin
      logic [31:0] r;
      logic [31:0] d;
      rst = 1'b1;
      cpu_req_i = 1'b0;
      cpu_op_i = OP_READ;
      cpu_adr_i = '0;
      cpu_dat_i = '0;
      cpu_bsel_i = '0;
      mem_ack_i = 1'b0;
      mem_dat_i = '0;
      for (int s = 0; s < 16; s++) begin
         ref_valid[0][s] = 1'b0;
         ref_valid[1][s] = 1'b0;
         ref_lru[s] = 1'b0;
      end
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);

      start_test();
      if (cpu_ack_o !== 1'b0) report_mismatch("cpu_ack_o", 0, cpu_ack_o);
      if (mem_req_o !== 1'b0) report_mismatch("mem_req_o", 0, mem_req_o);
      run_access(OP_READ, 32'h0000_1234, 0, 0);
      finish_test("reset and first read");

      start_test();
      run_access(OP_READ, 32'h0000_1234, 0, 0);
      run_access(OP_READ, 32'h0000_1238, 0, 0);
      finish_test("read hit");

      start_test();
      r = $random(stim_seed);
      d = $random(stim_seed);
      // Partial byte mask so that the merge is visible
      if (r[3:0] == 4'h0 || r[3:0] == 4'hf) begin
         r[3:0] = 4'h6;
      end
      run_access(OP_WRITE, 32'h0000_1234, d, r[3:0]);
      run_access(OP_READ, 32'h0000_1234, 0, 0);
      run_access(OP_WRITE, 32'h0000_5678, d, 4'hf);
      run_access(OP_READ, 32'h0000_5678, 0, 0);
      finish_test("write hit and write miss");

      // Three lines of set 5
      start_test();
      run_access(OP_READ, 32'h0000_1050, 0, 0);
      run_access(OP_READ, 32'h0000_2050, 0, 0);
      run_access(OP_READ, 32'h0000_1050, 0, 0);
      run_access(OP_READ, 32'h0000_3050, 0, 0);
      run_access(OP_READ, 32'h0000_1054, 0, 0);
      run_access(OP_READ, 32'h0000_2058, 0, 0);
      finish_test("lru replacement");

      // Set 5 now holds lines A and B
      start_test();
      run_access(OP_INVAL, 32'h0000_1050, 0, 0);
      run_access(OP_READ, 32'h0000_2050, 0, 0);
      run_access(OP_READ, 32'h0000_1050, 0, 0);
      finish_test("invalidate");

      // Small window keeps sets busy with four tags
      start_test();
      for (int i = 0; i < RANDOM_OPS; i++) begin
         r = $random(stim_seed);
         d = $random(stim_seed);
         if (r[2:0] == 3'd7) begin
            run_access(OP_INVAL, {22'd0, r[17:10], 2'b00}, 0, 0);
         end else if (r[2:0] >= 3'd4) begin
            run_access(OP_WRITE, {22'd0, r[17:10], 2'b00}, d, r[7:4]);
         end else begin
            run_access(OP_READ, {22'd0, r[17:10], 2'b00}, 0, 0);
         end
      end
      finish_test("random mix");

      $display("Tests %0d, failed tests %0d, failed checks %0d", test_cnt, test_fail, err_cnt);
      if (err_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+include
rtl/dcache_pkg.sv
rtl/dcache_tag_store.sv
rtl/dcache_data_store.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verif/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - include_dirs:
      - include
    files:
      - rtl/dcache_pkg.sv
      - rtl/dcache_tag_store.sv
      - rtl/dcache_data_store.sv
      - rtl/dcache_ctrl.sv
      - rtl/dcache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/dcache_tb.sv
